//--- mem_ex_latch.f
common/queue_pkg.sv
common/uop_pkg.sv
queue/entry_queue.sv
src/operand_wakeup.sv
src/mem_accept.sv
src/ex_issue.sv
src/mem_ex_latch.sv
verification/mem_ex_latch_properties.sv
verification/tb_mem_ex_latch.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f mem_ex_latch.f \
    --top-module tb_mem_ex_latch -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -qx "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- verification/tb_mem_ex_latch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ex_latch import queue_pkg::*, uop_pkg::*; ();

    localparam int depth      = depth_default;
    localparam int n_uops     = 6 + 1 + 1 + (depth + 2) + 6 + 40;
    localparam int max_cycles = 40 * n_uops + 200;

    logic                  clk;
    logic                  rst;
    logic                  clr;
    logic                  mem_req;
    operand_slot_t         mem_op1;
    operand_slot_t         mem_op2;
    logic [ctrl_width-1:0] mem_ctrl;
    logic                  mem_ack;
    logic                  ex_req;
    logic [word_width-1:0] ex_op1;
    logic [word_width-1:0] ex_op2;
    logic [ctrl_width-1:0] ex_ctrl;
    logic                  ex_ack;
    logic                  bc_valid;
    logic [tag_width-1:0]  bc_tag;
    logic [word_width-1:0] bc_value;

    integer seed;
    int     errors;
    int     checks;
    int     cycles = 0;
    string  test_name;
    logic   hold_ack;
    logic   random_delay;
    logic   sending;
    int     ack_wait;

    // reference queue and the uops it expects on the execute side
    operand_slot_t         q_op1[$];
    operand_slot_t         q_op2[$];
    logic [ctrl_width-1:0] q_ctrl[$];
    logic [word_width-1:0] e_op1[$];
    logic [word_width-1:0] e_op2[$];
    logic [ctrl_width-1:0] e_ctrl[$];

    // inputs as the DUT sees them at the next rising edge
    logic                  s_clr;
    logic                  s_bc_valid;
    logic [tag_width-1:0]  s_bc_tag;
    logic [word_width-1:0] s_bc_value;
    operand_slot_t         s_op1;
    operand_slot_t         s_op2;
    logic [ctrl_width-1:0] s_ctrl;
    logic                  p_mem_ack;
    logic                  p_ex_req;

    mem_ex_latch #(.DEPTH(depth)) dut0 (
        .clk      (clk),
        .rst      (rst),
        .clr      (clr),
        .mem_req  (mem_req),
        .mem_op1  (mem_op1),
        .mem_op2  (mem_op2),
        .mem_ctrl (mem_ctrl),
        .mem_ack  (mem_ack),
        .ex_req   (ex_req),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2),
        .ex_ctrl  (ex_ctrl),
        .ex_ack   (ex_ack),
        .bc_valid (bc_valid),
        .bc_tag   (bc_tag),
        .bc_value (bc_value)
    );

    always #50 clk = ~clk;

    // a pending slot with the broadcast tag becomes ready with the broadcast value
    function automatic operand_slot_t wake_slot(input operand_slot_t s, input logic v,
                                                input logic [tag_width-1:0] t,
                                                input logic [word_width-1:0] val);
        if (v && !s[slot_ready_bit] && s[tag_width-1:0] == t) begin
            return {1'b1, val};
        end
        return s;
    endfunction

    function automatic operand_slot_t ready_slot(input logic [word_width-1:0] v);
        return {1'b1, v};
    endfunction

    function automatic operand_slot_t pending_slot(input logic [tag_width-1:0] t);
        return {1'b0, {(word_width - tag_width){1'b0}}, t};
    endfunction

    function automatic logic [ctrl_width-1:0] rand_ctrl();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[ctrl_width-1:0];
    endfunction

    // one pending operand in three, tags from a small pool
    function automatic operand_slot_t random_slot();
        if ($unsigned($random(seed)) % 3 == 0) begin
            return pending_slot(tag_width'($unsigned($random(seed)) % 8));
        end
        return ready_slot($random(seed));
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic check_word(input string what, input logic [word_width-1:0] exp,
                              input logic [word_width-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_ctrl(input string what, input logic [ctrl_width-1:0] exp,
                              input logic [ctrl_width-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // four-phase send of one uop, returns once ack has dropped again
    task automatic send_uop(input operand_slot_t op1, input operand_slot_t op2,
                            input logic [ctrl_width-1:0] ctrl);
        mem_op1  = op1;
        mem_op2  = op2;
        mem_ctrl = ctrl;
        mem_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!mem_ack);
        mem_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (mem_ack);
    endtask

    task automatic broadcast(input logic [tag_width-1:0] t, input logic [word_width-1:0] v);
        bc_valid = 1'b1;
        bc_tag   = t;
        bc_value = v;
        @(posedge clk);
        #1;
        bc_valid = 1'b0;
    endtask

    task automatic expect_no_issue(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            if (ex_req) begin
                report_error("uop issued while an operand was still pending");
            end
        end
    endtask

    task automatic drain();
        while (q_ctrl.size() != 0 || e_ctrl.size() != 0 || ex_req || ex_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    // reference model, one step per rising edge
    always @(negedge clk) begin : model_update
        if (rst) begin
            q_op1.delete();
            q_op2.delete();
            q_ctrl.delete();
            e_op1.delete();
            e_op2.delete();
            e_ctrl.delete();
        end else begin
            if (ex_req && !p_ex_req) begin
                if (q_ctrl.size() == 0) begin
                    report_error("issue while the reference queue was empty");
                end else begin
                    if (!q_op1[0][slot_ready_bit] || !q_op2[0][slot_ready_bit]) begin
                        report_error("head issued before both operands were ready");
                    end
                    e_op1.push_back(q_op1[0][word_width-1:0]);
                    e_op2.push_back(q_op2[0][word_width-1:0]);
                    e_ctrl.push_back(q_ctrl[0]);
                    void'(q_op1.pop_front());
                    void'(q_op2.pop_front());
                    void'(q_ctrl.pop_front());
                end
            end
            if (s_clr) begin
                q_op1.delete();
                q_op2.delete();
                q_ctrl.delete();
            end else begin
                for (int i = 0; i < q_ctrl.size(); i++) begin
                    q_op1[i] = wake_slot(q_op1[i], s_bc_valid, s_bc_tag, s_bc_value);
                    q_op2[i] = wake_slot(q_op2[i], s_bc_valid, s_bc_tag, s_bc_value);
                end
                if (mem_ack && !p_mem_ack) begin
                    q_op1.push_back(wake_slot(s_op1, s_bc_valid, s_bc_tag, s_bc_value));
                    q_op2.push_back(wake_slot(s_op2, s_bc_valid, s_bc_tag, s_bc_value));
                    q_ctrl.push_back(s_ctrl);
                end
            end
        end
        s_clr      = clr;
        s_bc_valid = bc_valid;
        s_bc_tag   = bc_tag;
        s_bc_value = bc_value;
        s_op1      = mem_op1;
        s_op2      = mem_op2;
        s_ctrl     = mem_ctrl;
        p_mem_ack  = mem_ack;
        p_ex_req   = ex_req;
    end

    // exactly one rising edge sees req and ack both high per handshake
    always @(posedge clk) begin : compare_issue
        logic [word_width-1:0] w1;
        logic [word_width-1:0] w2;
        logic [ctrl_width-1:0] c;
        if (!rst && ex_req && ex_ack) begin
            if (e_ctrl.size() == 0) begin
                report_error("execute handshake with no uop expected");
            end else begin
                w1 = e_op1.pop_front();
                w2 = e_op2.pop_front();
                c  = e_ctrl.pop_front();
                check_word("op1", w1, ex_op1);
                check_word("op2", w2, ex_op2);
                check_ctrl("ctrl", c, ex_ctrl);
            end
        end
    end

    // execute stage side, optional random ack delay
    initial begin : ex_responder
        ex_ack   = 1'b0;
        ack_wait = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ex_ack && !ex_req) begin
                ex_ack   = 1'b0;
                ack_wait = random_delay ? int'($unsigned($random(seed)) % 5) : 0;
            end else if (ex_req && !ex_ack && !hold_ack) begin
                if (ack_wait == 0) begin
                    ex_ack = 1'b1;
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run stopped after %0d cycles with uops still outstanding", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        seed         = 32'h2352_2f2b;
        errors       = 0;
        checks       = 0;
        test_name    = "reset";
        clk          = 1'b0;
        rst          = 1'b1;
        clr          = 1'b0;
        mem_req      = 1'b0;
        mem_op1      = '0;
        mem_op2      = '0;
        mem_ctrl     = '0;
        bc_valid     = 1'b0;
        bc_tag       = '0;
        bc_value     = '0;
        hold_ack     = 1'b0;
        random_delay = 1'b0;
        sending      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        if (mem_ack !== 1'b0 || ex_req !== 1'b0) begin
            report_error("handshake outputs not low after reset");
        end

        test_name = "in_order";
        for (int i = 0; i < 6; i++) begin
            send_uop(ready_slot($random(seed)), ready_slot($random(seed)), rand_ctrl());
        end
        drain();

        test_name = "pending_operand";
        send_uop(pending_slot(6'd5), ready_slot(32'h1234_5678), rand_ctrl());
        expect_no_issue(4);
        broadcast(6'd6, 32'hdead_beef);
        expect_no_issue(4);
        broadcast(6'd5, 32'hcafe_f00d);
        drain();

        test_name = "same_edge_wakeup";
        fork
            send_uop(pending_slot(6'd9), pending_slot(6'd9), rand_ctrl());
            broadcast(6'd9, 32'h0bad_cafe);
        join
        drain();

        // one uop held in the issue stage, then a full queue
        test_name = "back_pressure";
        hold_ack  = 1'b1;
        for (int i = 0; i < depth + 1; i++) begin
            send_uop(ready_slot($random(seed)), ready_slot($random(seed)), rand_ctrl());
        end
        fork
            send_uop(ready_slot($random(seed)), ready_slot($random(seed)), rand_ctrl());
            begin
                repeat (20) begin
                    @(posedge clk);
                    #1;
                    if (mem_ack) begin
                        report_error("mem_ack given while the queue was full");
                    end
                end
                hold_ack = 1'b0;
            end
        join
        drain();

        test_name = "clear";
        hold_ack  = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send_uop(ready_slot($random(seed)), ready_slot($random(seed)), rand_ctrl());
        end
        clr = 1'b1;
        @(posedge clk);
        #1;
        clr      = 1'b0;
        hold_ack = 1'b0;
        drain();
        for (int i = 0; i < 2; i++) begin
            send_uop(ready_slot($random(seed)), ready_slot($random(seed)), rand_ctrl());
        end
        drain();

        test_name    = "random_mix";
        random_delay = 1'b1;
        sending      = 1'b1;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    send_uop(random_slot(), random_slot(), rand_ctrl());
                end
                sending = 1'b0;
            end
            while (sending) begin
                wait_cycles(int'($unsigned($random(seed)) % 3));
                broadcast(tag_width'($unsigned($random(seed)) % 8), $random(seed));
            end
        join
        // wake whatever is still pending
        for (int t = 0; t < 8; t++) begin
            broadcast(tag_width'(t), $random(seed));
        end
        drain();
        random_delay = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_ex_latch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ex_latch_properties import uop_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  mem_req,
    input logic                  mem_ack,
    input logic                  ex_req,
    input logic                  ex_ack,
    input logic [word_width-1:0] ex_op1,
    input logic [word_width-1:0] ex_op2,
    input logic [ctrl_width-1:0] ex_ctrl
);

    // issued uop stays put for the whole handshake
    ex_stable: assert property (@(posedge clk) disable iff (rst)
        ex_req && $past(ex_req) |-> $stable({ex_op1, ex_op2, ex_ctrl}))
        else $error("execute outputs changed while ex_req was high");

    // req only drops after the ack was seen
    ex_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(ex_req) |-> $past(ex_ack))
        else $error("ex_req dropped before ex_ack was seen");

    mem_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_ack) |-> $past(mem_req))
        else $error("mem_ack rose without a pending mem_req");

endmodule

bind mem_ex_latch mem_ex_latch_properties props0 (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .ex_req  (ex_req),
    .ex_ack  (ex_ack),
    .ex_op1  (ex_op1),
    .ex_op2  (ex_op2),
    .ex_ctrl (ex_ctrl)
);

`default_nettype wire

//--- src/mem_ex_latch.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ex_latch import queue_pkg::*, uop_pkg::*; #(
    parameter int DEPTH = depth_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    // memory stage side
    input  logic                  mem_req,
    input  operand_slot_t         mem_op1,
    input  operand_slot_t         mem_op2,
    input  logic [ctrl_width-1:0] mem_ctrl,
    output logic                  mem_ack,
    // execute stage side
    output logic                  ex_req,
    output logic [word_width-1:0] ex_op1,
    output logic [word_width-1:0] ex_op2,
    output logic [ctrl_width-1:0] ex_ctrl,
    input  logic                  ex_ack,
    // result broadcast
    input  logic                  bc_valid,
    input  logic [tag_width-1:0]  bc_tag,
    input  logic [word_width-1:0] bc_value
);

    logic                         wr;
    logic                         rd;
    logic                         full;
    logic                         empty;
    logic [mpart_width-1:0]       head_mpart;
    logic [ctrl_width-1:0]        head_ctrl;
    logic [mpart_width*DEPTH-1:0] old_m_vector;
    logic [mpart_width*DEPTH-1:0] new_m_vector;
    logic [DEPTH-1:0]             modify_vector;
    operand_slot_t                woken_op1;
    operand_slot_t                woken_op2;

    mem_accept u_accept (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .full    (full),
        .mem_ack (mem_ack),
        .wr      (wr)
    );

    operand_wakeup #(.DEPTH(DEPTH)) u_wakeup (
        .bc_valid      (bc_valid),
        .bc_tag        (bc_tag),
        .bc_value      (bc_value),
        .old_m_vector  (old_m_vector),
        .in_op1        (mem_op1),
        .in_op2        (mem_op2),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .out_op1       (woken_op1),
        .out_op2       (woken_op2)
    );

    entry_queue #(.DEPTH(DEPTH)) u_queue (
        .clk           (clk),
        .rst           (rst),
        .clr           (clr),
        .wr            (wr),
        .rd            (rd),
        .din_m         ({woken_op1, woken_op2}),
        .din_n         (mem_ctrl),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .head_m        (head_mpart),
        .head_n        (head_ctrl)
    );

    ex_issue u_issue (
        .clk     (clk),
        .rst     (rst),
        .head_m  (head_mpart),
        .head_n  (head_ctrl),
        .empty   (empty),
        .ex_ack  (ex_ack),
        .rd      (rd),
        .ex_req  (ex_req),
        .ex_op1  (ex_op1),
        .ex_op2  (ex_op2),
        .ex_ctrl (ex_ctrl)
    );

endmodule

`default_nettype wire

//--- src/ex_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ex_issue import uop_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [mpart_width-1:0] head_m,
    input  logic [ctrl_width-1:0]  head_n,
    input  logic                   empty,
    input  logic                   ex_ack,
    output logic                   rd,
    output logic                   ex_req,
    output logic [word_width-1:0]  ex_op1,
    output logic [word_width-1:0]  ex_op2,
    output logic [ctrl_width-1:0]  ex_ctrl
);

    operand_slot_t head_op1;
    operand_slot_t head_op2;
    logic          head_ready;

    assign head_op1 = head_m[slot_width +: slot_width];
    assign head_op2 = head_m[0 +: slot_width];

    assign head_ready = head_op1[slot_ready_bit] && head_op2[slot_ready_bit];

    // start a new handshake only after the previous ack has gone low
    assign rd = !ex_req && !ex_ack && !empty && head_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_req <= 1'b0;
        end else if (rd) begin
            ex_req <= 1'b1;
        end else if (ex_req && ex_ack) begin
            ex_req <= 1'b0;
        end
    end

    // held copy of the issued uop, frees the queue head right away
    always_ff @(posedge clk) begin
        if (rd) begin
            ex_op1  <= head_op1[word_width-1:0];
            ex_op2  <= head_op2[word_width-1:0];
            ex_ctrl <= head_n;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_accept.sv
`timescale 1ns/1ps
`default_nettype none

module mem_accept (
    input  logic clk,
    input  logic rst,
    input  logic mem_req,
    input  logic full,
    output logic mem_ack,
    output logic wr
);

    localparam logic s_idle = 1'b0;
    localparam logic s_ack  = 1'b1;

    logic state;

    // take the entry only when there is room, otherwise the request waits
    assign wr = (state == s_idle) && mem_req && !full;

    assign mem_ack = (state == s_ack);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (wr) begin
                        state <= s_ack;
                    end
                end
                s_ack: begin
                    // hold ack until the sender drops its request
                    if (!mem_req) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/operand_wakeup.sv
`timescale 1ns/1ps
`default_nettype none

module operand_wakeup import queue_pkg::*, uop_pkg::*; #(
    parameter int DEPTH = depth_default
) (
    input  logic                         bc_valid,
    input  logic [tag_width-1:0]         bc_tag,
    input  logic [word_width-1:0]        bc_value,
    input  logic [mpart_width*DEPTH-1:0] old_m_vector,
    input  operand_slot_t                in_op1,
    input  operand_slot_t                in_op2,
    output logic [mpart_width*DEPTH-1:0] new_m_vector,
    output logic [DEPTH-1:0]             modify_vector,
    output operand_slot_t                out_op1,
    output operand_slot_t                out_op2
);

    // a pending slot whose tag matches the broadcast
    function automatic logic slot_hit(input operand_slot_t slot, input logic v,
                                      input logic [tag_width-1:0] t);
        operand_word_t word;
        word = slot[word_width-1:0];
        return v && !slot[slot_ready_bit] && (word.pending.tag == t);
    endfunction

    operand_slot_t woken;

    assign woken = {1'b1, bc_value};

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        operand_slot_t op1;
        operand_slot_t op2;
        logic          hit1;
        logic          hit2;

        assign op1  = old_m_vector[i*mpart_width + slot_width +: slot_width];
        assign op2  = old_m_vector[i*mpart_width +: slot_width];
        assign hit1 = slot_hit(op1, bc_valid, bc_tag);
        assign hit2 = slot_hit(op2, bc_valid, bc_tag);

        assign new_m_vector[i*mpart_width +: mpart_width] = {hit1 ? woken : op1,
                                                              hit2 ? woken : op2};
        // only entries that actually changed get rewritten
        assign modify_vector[i] = hit1 || hit2;
    end

    // same rule for the uop being written this cycle
    assign out_op1 = slot_hit(in_op1, bc_valid, bc_tag) ? woken : in_op1;
    assign out_op2 = slot_hit(in_op2, bc_valid, bc_tag) ? woken : in_op2;

endmodule

`default_nettype wire

//--- queue/entry_queue.sv
`timescale 1ns/1ps
`default_nettype none

module entry_queue import queue_pkg::*, uop_pkg::*; #(
    parameter int DEPTH = depth_default
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         clr,
    input  logic                         wr,
    input  logic                         rd,
    input  logic [mpart_width-1:0]       din_m,
    input  logic [ctrl_width-1:0]        din_n,
    input  logic [mpart_width*DEPTH-1:0] new_m_vector,
    input  logic [DEPTH-1:0]             modify_vector,
    output logic                         full,
    output logic                         empty,
    output logic [mpart_width*DEPTH-1:0] old_m_vector,
    output logic [mpart_width-1:0]       head_m,
    output logic [ctrl_width-1:0]        head_n
);

    localparam int iw = idx_width(DEPTH);
    localparam int cw = cnt_width(DEPTH);

    // modifiable and fixed parts live in separate arrays
    logic [mpart_width-1:0] m_mem [DEPTH];
    logic [ctrl_width-1:0]  n_mem [DEPTH];

    logic [iw-1:0] head;
    logic [iw-1:0] tail;
    logic [cw-1:0] count;

    logic do_wr;
    logic do_rd;

    assign full  = (count == cw'(DEPTH));
    assign empty = (count == '0);

    // ignore a write into a full queue or a read from an empty one
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clr) begin
            // redirect drops everything queued, including a write at this edge
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                tail <= tail + 1'b1;
            end
            if (do_rd) begin
                head <= head + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // modifiable part, new entry at tail or in-place wakeup elsewhere
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (do_wr && tail == iw'(i)) begin
                // incoming operands already carry this cycle's wakeup
                m_mem[i] <= din_m;
            end else if (modify_vector[i]) begin
                m_mem[i] <= new_m_vector[i*mpart_width +: mpart_width];
            end
        end
    end

    // fixed part is written once and never touched again
    always_ff @(posedge clk) begin
        if (do_wr) begin
            n_mem[tail] <= din_n;
        end
    end

    // every stored modifiable part, slot 0 in the low bits
    for (genvar i = 0; i < DEPTH; i++) begin : g_old
        assign old_m_vector[i*mpart_width +: mpart_width] = m_mem[i];
    end

    assign head_m = m_mem[head];
    assign head_n = n_mem[head];

endmodule

`default_nettype wire

//--- common/uop_pkg.sv
`default_nettype none

package uop_pkg;

    // producer tag and operand value
    localparam int tag_width  = 6;
    localparam int word_width = 32;

    // fixed part fields, msb first: aluk, dest, flag mask, eip
    localparam int aluk_width  = 5;
    localparam int dest_width  = 4;
    localparam int fmask_width = 7;
    localparam int eip_width   = 32;
    localparam int ctrl_width  = aluk_width + dest_width + fmask_width + eip_width;

    // one operand word, seen either as a full value or as a pending tag
    typedef union packed {
        logic [word_width-1:0] value;
        struct packed {
            logic [word_width-tag_width-1:0] pad;
            logic [tag_width-1:0]            tag;
        } pending;
    } operand_word_t;

    // slot layout is {ready, word}
    localparam int slot_width     = word_width + 1;
    localparam int slot_ready_bit = word_width;

    typedef logic [slot_width-1:0] operand_slot_t;

    // modifiable part holds {op1, op2}
    localparam int mpart_width = 2 * slot_width;

endpackage

`default_nettype wire

//--- common/queue_pkg.sv
`default_nettype none

package queue_pkg;

    // default number of queue entries
    // any power of two from 2 up works
    localparam int depth_default = 8;

    // width of the head and tail pointers
    function automatic int idx_width(input int depth);
        if (depth > 1) begin
            return $clog2(depth);
        end
        return 1;
    endfunction

    // occupancy counter runs from 0 to depth inclusive,
    // so it needs one bit more than a pointer
    function automatic int cnt_width(input int depth);
        return idx_width(depth) + 1;
    endfunction

endpackage

`default_nettype wire
